// ==== rtl/spi_pkg.sv ====
// spi framing for an 8-bit command / 32-bit status target; 3-stage sync assumes sck well below clk/6

package spi_pkg;

  //////////////////////////////////////////////////////////////////////
  // frame widths

  // command bytes from the host
  localparam int byte_width = 8;

  // status word shifted back on miso
  localparam int word_width = 32;

  //////////////////////////////////////////////////////////////////////
  // synchronizer

  // stages per pin, the two oldest feed the edge compare
  localparam int sync_depth = 3;

  //////////////////////////////////////////////////////////////////////
  // payload types

  typedef logic [byte_width-1:0] byte_t;

  typedef logic [word_width-1:0] word_t;

  // bit position inside one received byte
  typedef logic [$clog2(byte_width)-1:0] bit_count_t;

endpackage

// ==== rtl/integ_pkg.sv ====
// integrator command set and counter types; codes outside this set are ignored by the controller

package integ_pkg;

  //////////////////////////////////////////////////////////////////////
  // command codes

  // open the reset switch, m_reset high
  localparam spi_pkg::byte_t cmd_integrate = 8'hca;

  // close the reset switch and short the cap
  localparam spi_pkg::byte_t cmd_short = 8'hcb;

  // zero the cycle count
  localparam spi_pkg::byte_t cmd_clear = 8'hcc;

  // input switched to 0 v, m_in high
  localparam spi_pkg::byte_t cmd_in_low_v = 8'hcd;

  // input switched to 5 v, m_in low
  localparam spi_pkg::byte_t cmd_in_high_v = 8'hce;

  //////////////////////////////////////////////////////////////////////
  // counters

  // free-running cycle count, same width as the miso word
  typedef logic [$bits(spi_pkg::word_t)-1:0] count_t;

  // divider bit for the blink led
  // bit 22 gives a visible blink at tens of mhz
  localparam int hb_bit_default = 22;

endpackage

// ==== rtl/spi_edge_sync.sv ====
// pins are async to clk; each sck level must last 3+ clk cycles or edges are lost

`timescale 1ns/100ps

module spi_edge_sync (
  input  logic clk,
  input  logic rst,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic sck_rise,
  output logic sck_fall,
  output logic sel_active,
  output logic sel_start,
  output logic mosi_data
);

  localparam int top = spi_pkg::sync_depth - 1;

  // sync chains, index 0 is nearest the pin
  logic [top:0] sck_r;
  logic [top:0] ssel_r;
  logic [top:0] mosi_r;

  //////////////////////////////////////////////////////////////////////
  // synchronizers and registered edge pulses

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sck_r     <= '0;
      // select idles high
      ssel_r    <= '1;
      mosi_r    <= '0;
      sck_rise  <= 1'b0;
      sck_fall  <= 1'b0;
      sel_start <= 1'b0;
    end
    else
    begin
      sck_r  <= {sck_r[top-1:0], sck};
      ssel_r <= {ssel_r[top-1:0], ssel};
      mosi_r <= {mosi_r[top-1:0], mosi};
      // compare the two oldest stages
      sck_rise  <= (sck_r[top:top-1] == 2'b01);
      sck_fall  <= (sck_r[top:top-1] == 2'b10);
      // frame starts on the select fall
      sel_start <= (ssel_r[top:top-1] == 2'b10);
    end
  end

  // oldest stage, lines up with the registered pulses
  assign sel_active = ~ssel_r[top];
  assign mosi_data  = mosi_r[top];

endmodule

// ==== rtl/spi_shifter.sv ====
// msb-first shift register of any packed payload; load wins over shift in the same cycle

`timescale 1ns/100ps

module spi_shifter #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     load,
  input  payload_t load_data,
  input  logic     shift,
  input  logic     serial_in,
  output payload_t data,
  output logic     serial_out
);

  localparam int width = $bits(payload_t);

  // bits below the msb, refilled from serial_in
  logic [width-2:0] low_bits;

  assign low_bits = data[width-2:0];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      data <= '0;
    end
    else if (load)
    begin
      data <= load_data;
    end
    else if (shift)
    begin
      // left shift, new bit enters at the lsb
      data <= payload_t'({low_bits, serial_in});
    end
  end

  // msb leaves first
  assign serial_out = data[width-1];

endmodule

// ==== rtl/spi_target.sv ====
// spi mode 0 target, single device on the bus so miso is never tri-stated

`timescale 1ns/100ps

module spi_target (
  input  logic           clk,
  input  logic           rst,
  input  logic           sck,
  input  logic           ssel,
  input  logic           mosi,
  input  spi_pkg::word_t tx_word,
  output logic           miso,
  output logic           cmd_valid,
  output spi_pkg::byte_t cmd_byte
);

  logic sck_rise;
  logic sck_fall;
  logic sel_active;
  logic sel_start;
  logic mosi_data;

  spi_pkg::bit_count_t bit_cnt;

  spi_edge_sync sync_i (
    .clk        (clk),
    .rst        (rst),
    .sck        (sck),
    .ssel       (ssel),
    .mosi       (mosi),
    .sck_rise   (sck_rise),
    .sck_fall   (sck_fall),
    .sel_active (sel_active),
    .sel_start  (sel_start),
    .mosi_data  (mosi_data)
  );

  //////////////////////////////////////////////////////////////////////
  // receive side

  // held at zero outside a frame, drops partial bytes
  always_ff @(posedge clk)
  begin
    if (rst || !sel_active)
      bit_cnt <= '0;
    else if (sck_rise)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // pulse lands with the last bit in the receive shifter
  always_ff @(posedge clk)
  begin
    if (rst)
      cmd_valid <= 1'b0;
    else
      cmd_valid <= sel_active && sck_rise &&
                   (bit_cnt == spi_pkg::bit_count_t'(spi_pkg::byte_width - 1));
  end

  // no parallel load on the receiver
  spi_shifter #(.payload_t(spi_pkg::byte_t)) rx_i (
    .clk        (clk),
    .rst        (rst),
    .load       (1'b0),
    .load_data  ('0),
    .shift      (sel_active && sck_rise),
    .serial_in  (mosi_data),
    .data       (cmd_byte),
    .serial_out ()
  );

  //////////////////////////////////////////////////////////////////////
  // transmit side

  // word latched at select fall, zeros shifted in behind it
  spi_shifter #(.payload_t(spi_pkg::word_t)) tx_i (
    .clk        (clk),
    .rst        (rst),
    .load       (sel_start),
    .load_data  (tx_word),
    .shift      (sel_active && sck_fall),
    .serial_in  (1'b0),
    .data       (),
    .serial_out (miso)
  );

endmodule

// ==== rtl/integ_ctrl.sv ====
// switch controls for the integrator; unknown command bytes leave all state as it was

`timescale 1ns/100ps

module integ_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic             cmd_valid,
  input  spi_pkg::byte_t   cmd_byte,
  output logic             m_reset,
  output logic             m_in,
  output logic             m_ref,
  output logic             led_status,
  output integ_pkg::count_t count
);

  //////////////////////////////////////////////////////////////////////
  // switch registers

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // cap shorted, input at 5 v
      m_reset <= 1'b0;
      m_in    <= 1'b0;
    end
    else if (cmd_valid)
    begin
      case (cmd_byte)
        integ_pkg::cmd_integrate: m_reset <= 1'b1;
        integ_pkg::cmd_short:     m_reset <= 1'b0;
        integ_pkg::cmd_in_low_v:  m_in    <= 1'b1;
        integ_pkg::cmd_in_high_v: m_in    <= 1'b0;
        // clear handled by the counter
        default:                  ;
      endcase
    end
  end

  // reference switch is always the complement
  assign m_ref = ~m_in;

  // status led lit while integrating
  assign led_status = m_reset;

  //////////////////////////////////////////////////////////////////////
  // cycle count

  // host reads this to time the integration
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (cmd_valid && (cmd_byte == integ_pkg::cmd_clear))
      count <= '0;
    else
      count <= count + 1'b1;
  end

endmodule

// ==== rtl/heartbeat.sv ====
// blink led from a free-running divider; hb_bit must be below the counter width of 32

`timescale 1ns/100ps

module heartbeat #(
  parameter int hb_bit = integ_pkg::hb_bit_default
) (
  input  logic clk,
  input  logic rst,
  output logic led
);

  integ_pkg::count_t div_cnt;

  always_ff @(posedge clk)
  begin
    if (rst)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // toggles every 2**hb_bit cycles
  assign led = div_cnt[hb_bit];

endmodule

// ==== rtl/integ_top.sv ====
// board top for the integrator switches; no logic-supply output, vl is tied on the board

`timescale 1ns/100ps

module integ_top #(
  parameter int hb_bit = integ_pkg::hb_bit_default
) (
  input  logic clk,
  input  logic rst,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic miso,
  output logic led_heartbeat,
  output logic led_status,
  output logic m_reset,
  output logic m_in,
  output logic m_ref
);

  logic              cmd_valid;
  spi_pkg::byte_t    cmd_byte;
  integ_pkg::count_t count;

  //////////////////////////////////////////////////////////////////////
  // spi front end

  spi_target spi_target_i (
    .clk       (clk),
    .rst       (rst),
    .sck       (sck),
    .ssel      (ssel),
    .mosi      (mosi),
    .tx_word   (count),
    .miso      (miso),
    .cmd_valid (cmd_valid),
    .cmd_byte  (cmd_byte)
  );

  //////////////////////////////////////////////////////////////////////
  // command decode and switch drive

  integ_ctrl integ_ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd_byte   (cmd_byte),
    .m_reset    (m_reset),
    .m_in       (m_in),
    .m_ref      (m_ref),
    .led_status (led_status),
    .count      (count)
  );

  // stand-alone blink
  heartbeat #(.hb_bit(hb_bit)) heartbeat_i (
    .clk (clk),
    .rst (rst),
    .led (led_heartbeat)
  );

endmodule

// ==== dv/integ_assert.sv ====
// switch output rules for integ_ctrl, sampled on clk; attached by bind, checks only after reset

`timescale 1ns/100ps

module integ_assert (
  input logic clk,
  input logic rst,
  input logic cmd_valid,
  input logic m_reset,
  input logic m_in,
  input logic m_ref
);

  // reference switch is the complement of the input switch
  ref_inverse: assert property (@(posedge clk) disable iff (rst) m_ref == !m_in)
    else $error("m_ref is not the inverse of m_in");

  // cap shorted and input at 5 v right after reset
  reset_state: assert property (@(posedge clk) rst |=> (!m_reset && !m_in))
    else $error("m_reset or m_in high in the cycle after reset");

  // reset switch moves only on a command
  reset_change: assert property (@(posedge clk) disable iff (rst)
                                 (m_reset != $past(m_reset)) |-> $past(cmd_valid))
    else $error("m_reset changed without a command in the cycle before");

endmodule

bind integ_ctrl integ_assert integ_assert_i (
  .clk       (clk),
  .rst       (rst),
  .cmd_valid (cmd_valid),
  .m_reset   (m_reset),
  .m_in      (m_in),
  .m_ref     (m_ref)
);

// ==== dv/integ_tb.sv ====
// directed tests for integ_top; host model uses sck half periods of 4 clk cycles, miso read at negedge

`timescale 1ns/100ps

module integ_tb;

  // sck half period in clk cycles
  localparam int sck_half = 4;
  // settle time after a command frame
  localparam int settle = 20;
  // heartbeat watch window
  localparam int hb_window = 200;

  logic clk;
  logic rst;
  logic sck;
  logic ssel;
  logic mosi;
  logic miso;
  logic led_heartbeat;
  logic led_status;
  logic m_reset;
  logic m_in;
  logic m_ref;

  // host side timing marks, in clk cycles
  int unsigned cyc = 0;
  int unsigned last_rise_cyc;
  int unsigned sel_fall_cyc;

  integ_top #(.hb_bit(4)) integ_top_i (
    .clk           (clk),
    .rst           (rst),
    .sck           (sck),
    .ssel          (ssel),
    .mosi          (mosi),
    .miso          (miso),
    .led_heartbeat (led_heartbeat),
    .led_status    (led_status),
    .m_reset       (m_reset),
    .m_in          (m_in),
    .m_ref         (m_ref)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  //////////////////////////////////////////////////////////////////////
  // helpers

  task automatic fail_stop(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      fail_stop($sformatf("mismatch at %0t: %s got 0x%0h expected 0x%0h",
                          $time, what, got, exp));
  endtask

  // all waits land on a falling edge
  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++)
      @(negedge clk);
  endtask

  // one frame, bits leave from tx[nbits-1] down to tx[0]
  task automatic spi_frame(input logic [31:0] tx, input int nbits, output logic [31:0] rx);
    rx = '0;
    @(negedge clk);
    ssel = 1'b0;
    sel_fall_cyc = cyc;
    // leaves room for the count load
    wait_cycles(8);
    for (int b = nbits - 1; b >= 0; b--)
    begin
      mosi = tx[b];
      wait_cycles(sck_half);
      // miso has moved since the last sck fall
      rx = {rx[30:0], miso};
      sck = 1'b1;
      last_rise_cyc = cyc;
      wait_cycles(sck_half);
      sck = 1'b0;
    end
    wait_cycles(sck_half);
    ssel = 1'b1;
    mosi = 1'b0;
    // select high long enough for the sync chain
    wait_cycles(sck_half);
  endtask

  task automatic send_command(input logic [7:0] code);
    logic [31:0] rx;
    spi_frame({24'h0, code}, 8, rx);
    wait_cycles(settle);
  endtask

  // m_ref and led_status follow from the two switch levels
  task automatic verify_outputs(input logic exp_reset, input logic exp_in);
    check("m_reset", 32'(m_reset), 32'(exp_reset));
    check("led_status", 32'(led_status), 32'(exp_reset));
    check("m_in", 32'(m_in), 32'(exp_in));
    check("m_ref", 32'(m_ref), 32'(!exp_in));
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic reset_values;
    verify_outputs(1'b0, 1'b0);
    check("miso after reset", 32'(miso), 32'd0);
    check("heartbeat led after reset", 32'(led_heartbeat), 32'd0);
  endtask

  task automatic switch_commands;
    send_command(integ_pkg::cmd_integrate);
    verify_outputs(1'b1, 1'b0);
    send_command(integ_pkg::cmd_short);
    verify_outputs(1'b0, 1'b0);
    send_command(integ_pkg::cmd_in_low_v);
    verify_outputs(1'b0, 1'b1);
    send_command(integ_pkg::cmd_in_high_v);
    verify_outputs(1'b0, 1'b0);
  endtask

  task automatic unknown_codes;
    logic [31:0] rx;
    send_command(integ_pkg::cmd_integrate);
    verify_outputs(1'b1, 1'b0);
    send_command(8'h00);
    verify_outputs(1'b1, 1'b0);
    send_command(8'hff);
    verify_outputs(1'b1, 1'b0);
    // top five bits of short only
    spi_frame(32'(integ_pkg::cmd_short >> 3), 5, rx);
    wait_cycles(settle);
    verify_outputs(1'b1, 1'b0);
    // next byte must still line up
    send_command(integ_pkg::cmd_in_low_v);
    verify_outputs(1'b1, 1'b1);
    send_command(integ_pkg::cmd_short);
    send_command(integ_pkg::cmd_in_high_v);
    verify_outputs(1'b0, 1'b0);
  endtask

  task automatic count_readback;
    logic [31:0] rx;
    logic [31:0] first_read;
    logic [31:0] second_read;
    int unsigned clear_rise;
    int unsigned expected;
    int diff;
    spi_frame({24'h0, integ_pkg::cmd_clear}, 8, rx);
    clear_rise = last_rise_cyc;
    wait_cycles(40);
    // zero bytes are ignored codes, safe to clock the count out
    spi_frame(32'h0, 32, first_read);
    // sync latency on both ends mostly cancels
    expected = sel_fall_cyc - clear_rise;
    diff = int'(first_read) - int'(expected);
    if (diff > 4 || diff < -4)
      check("count readback", first_read, expected);
    wait_cycles(50);
    spi_frame(32'h0, 32, second_read);
    check("second count read larger", 32'(second_read > first_read), 32'd1);
  endtask

  task automatic multi_byte_frame;
    logic [31:0] rx;
    spi_frame({16'h0, integ_pkg::cmd_integrate, integ_pkg::cmd_in_low_v}, 16, rx);
    wait_cycles(settle);
    verify_outputs(1'b1, 1'b1);
  endtask

  task automatic heartbeat_blink;
    logic prev;
    int toggles;
    toggles = 0;
    prev = led_heartbeat;
    for (int i = 0; i < hb_window && toggles < 4; i++)
    begin
      @(negedge clk);
      if (led_heartbeat != prev)
        toggles++;
      prev = led_heartbeat;
    end
    if (toggles < 4)
      fail_stop($sformatf("heartbeat led toggled only %0d times in %0d cycles",
                          toggles, hb_window));
  endtask

  //////////////////////////////////////////////////////////////////////
  // sequence

  initial
  begin
    rst = 1'b1;
    sck = 1'b0;
    ssel = 1'b1;
    mosi = 1'b0;
    wait_cycles(16);
    rst = 1'b0;
    @(negedge clk);
    reset_values();
    switch_commands();
    unknown_codes();
    count_readback();
    multi_byte_frame();
    heartbeat_blink();
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== build.f ====
rtl/spi_pkg.sv
rtl/integ_pkg.sv
rtl/spi_edge_sync.sv
rtl/spi_shifter.sv
rtl/spi_target.sv
rtl/integ_ctrl.sv
rtl/heartbeat.sv
rtl/integ_top.sv
dv/integ_assert.sv
dv/integ_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile with Verilator and run the integ_tb simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module integ_tb
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/Vinteg_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
  exit 0
fi
echo "pass message not found in simulator output"
exit 1
